/* bench/mem_model.sv */
// Word memory for the pipeline testbench
// Read is combinational, write lands on the rising clock edge
// 256 words, addresses wrap modulo the depth
// Contents come only from the tests, which write mem directly

`timescale 1ns/10ps

module mem_model (
  input  logic               clock,
  input  proc_pkg::mem_req_t req,
  output proc_pkg::word_t    rdata
);

  localparam int addr_bits = 8;                 // 256 words

  proc_pkg::word_t mem [1 << addr_bits];

  // Same-cycle read for fetch and load
  assign rdata = mem[req.addr[addr_bits-1:0]];

  // Store port
  always @(posedge clock)
  begin
    if (req.cmd == proc_pkg::bus_store)
      mem[req.addr[addr_bits-1:0]] <= req.data;
  end

endmodule

/* bench/pipeline_tb.sv */
// Directed tests for the five-stage core
// Outputs sampled and reset driven on the falling clock edge
// Expected commits come from an instruction-level model of the ISA
// 256-word memory with programs from address 0 and data near 100

`timescale 1ns/10ps

module pipeline_tb;

  localparam int mem_bits         = 8;
  localparam int mem_words        = 1 << mem_bits;
  localparam int reset_cycles     = 5;
  localparam int cycles_per_instr = 4;    // F to commit
  localparam int max_instrs       = 40;   // Per program
  localparam int test_count       = 6;
  localparam int timeout_cycles   = 2 * test_count * (max_instrs * cycles_per_instr
                                                      + reset_cycles + 1);

  logic                clock;
  logic                reset;
  proc_pkg::word_t     mem_rdata;
  proc_pkg::mem_req_t  mem_req;
  proc_pkg::commit_t   commit;
  proc_pkg::status_t   status;

  // Reference model state
  proc_pkg::word_t     ref_mem  [mem_words];
  proc_pkg::word_t     ref_regs [proc_pkg::reg_count];
  proc_pkg::word_t     ref_pc;
  proc_pkg::status_t   ref_status;

  proc_pkg::word_t     program_q [$];   // Program of the current test
  proc_pkg::word_t     rng_state;
  int                  cycle_count;

  pipeline_top uut (
    .clock     (clock),
    .reset     (reset),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req),
    .commit    (commit),
    .status    (status)
  );

  mem_model memory (
    .clock (clock),
    .req   (mem_req),
    .rdata (mem_rdata)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;   // 40 ns period
  end

  always @(posedge clock)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
      fail_run("simulation did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input proc_pkg::word_t exp,
                          input proc_pkg::word_t act);
    fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic compare_commit(input proc_pkg::commit_t exp, input proc_pkg::commit_t act);
    if (act.pc !== exp.pc)
      mismatch("commit.pc", exp.pc, act.pc);
    if (act.wr_en !== exp.wr_en)
      mismatch("commit.wr_en", exp.wr_en, act.wr_en);
    if (act.wr_idx !== exp.wr_idx)
      mismatch("commit.wr_idx", exp.wr_idx, act.wr_idx);
    if (exp.wr_en && (act.wr_data !== exp.wr_data))    // Data only counts when written
      mismatch("commit.wr_data", exp.wr_data, act.wr_data);
    if (act.redirect !== exp.redirect)
      mismatch("commit.redirect", exp.redirect, act.redirect);
    if (exp.redirect && (act.target !== exp.target))
      mismatch("commit.target", exp.target, act.target);
  endtask

  task automatic compare_status(input proc_pkg::status_t exp, input proc_pkg::status_t act);
    if (act !== exp)
      mismatch("status", exp, act);
  endtask

  task automatic compare_req(input proc_pkg::mem_req_t exp, input proc_pkg::mem_req_t act);
    if (act.cmd !== exp.cmd)
      mismatch("mem_req.cmd", exp.cmd, act.cmd);
    if ((exp.cmd != proc_pkg::bus_none) && (act.addr !== exp.addr))
      mismatch("mem_req.addr", exp.addr, act.addr);
    if ((exp.cmd == proc_pkg::bus_store) && (act.data !== exp.data))
      mismatch("mem_req.data", exp.data, act.data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic proc_pkg::word_t next_random();
    rng_state = rng_state ^ (rng_state << 13);   // xorshift32
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic proc_pkg::word_t encode(input logic [3:0] op, input int rd,
                                             input int ra, input int rb, input int imm);
    proc_pkg::word_t w;
    w = '0;
    w[proc_pkg::op_hi:proc_pkg::op_lo]   = op;
    w[proc_pkg::rd_hi:proc_pkg::rd_lo]   = rd[2:0];
    w[proc_pkg::ra_hi:proc_pkg::ra_lo]   = ra[2:0];
    w[proc_pkg::rb_hi:proc_pkg::rb_lo]   = rb[2:0];
    w[proc_pkg::imm_hi:proc_pkg::imm_lo] = imm[15:0];
    return w;
  endfunction

  // Unused words differ at every address
  function automatic proc_pkg::word_t fill_word(input int addr);
    return proc_pkg::word_t'(addr) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Instruction-level reference model called once per retiring instruction
  //////////////////////////////////////////////////////////////////////
  task automatic model_retire(output proc_pkg::commit_t exp_commit,
                              output proc_pkg::status_t exp_status,
                              output proc_pkg::mem_req_t exp_data_req);
    proc_pkg::word_t    inst;
    logic [3:0]         op;
    logic [2:0]         rd;
    logic [2:0]         ra;
    logic [2:0]         rb;
    logic signed [15:0] imm16;
    int                 imm_int;
    proc_pkg::word_t    imm;
    proc_pkg::word_t    a;
    proc_pkg::word_t    b;
    proc_pkg::word_t    addr;
    proc_pkg::word_t    value;
    logic               writes;
    inst    = ref_mem[ref_pc[mem_bits-1:0]];
    op      = inst[proc_pkg::op_hi:proc_pkg::op_lo];
    rd      = inst[proc_pkg::rd_hi:proc_pkg::rd_lo];
    ra      = inst[proc_pkg::ra_hi:proc_pkg::ra_lo];
    rb      = inst[proc_pkg::rb_hi:proc_pkg::rb_lo];
    imm16   = inst[proc_pkg::imm_hi:proc_pkg::imm_lo];
    imm_int = imm16;                  // Sign extension
    imm     = proc_pkg::word_t'(imm_int);
    a       = ref_regs[ra];           // r0 is never written and stays zero
    b       = ref_regs[rb];
    addr    = a + imm;
    value   = '0;
    writes  = 1'b0;
    exp_status        = proc_pkg::st_running;
    exp_data_req.cmd  = proc_pkg::bus_none;
    exp_data_req.addr = addr;
    exp_data_req.data = b;
    case (op)
      proc_pkg::op_add:  begin value = a + b;   writes = 1'b1; end
      proc_pkg::op_sub:  begin value = a - b;   writes = 1'b1; end
      proc_pkg::op_and:  begin value = a & b;   writes = 1'b1; end
      proc_pkg::op_or:   begin value = a | b;   writes = 1'b1; end
      proc_pkg::op_addi: begin value = a + imm; writes = 1'b1; end
      proc_pkg::op_load:
      begin
        value  = ref_mem[addr[mem_bits-1:0]];
        writes = 1'b1;
        exp_data_req.cmd = proc_pkg::bus_load;
      end
      proc_pkg::op_store:
      begin
        ref_mem[addr[mem_bits-1:0]] = b;
        exp_data_req.cmd = proc_pkg::bus_store;
      end
      proc_pkg::op_beq:  value = '0;               // Compare only
      proc_pkg::op_halt: exp_status = proc_pkg::st_halted;
      default:           exp_status = proc_pkg::st_illegal;
    endcase
    exp_commit.valid    = 1'b1;
    exp_commit.pc       = ref_pc;
    exp_commit.wr_en    = writes && (rd != 3'd0);
    exp_commit.wr_idx   = rd;
    exp_commit.wr_data  = value;
    exp_commit.redirect = (op == proc_pkg::op_beq) && (a == b);
    exp_commit.target   = ref_pc + 32'd1 + imm;
    if (exp_commit.wr_en)
      ref_regs[rd] = value;
    ref_pc     = exp_commit.redirect ? exp_commit.target : ref_pc + 32'd1;
    ref_status = exp_status;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program run
  //////////////////////////////////////////////////////////////////////
  // Loads program_q under reset and returns in cycle F of the first fetch
  task automatic start_program();
    proc_pkg::mem_req_t first_fetch;
    @(negedge clock);
    reset = 1'b1;
    repeat (reset_cycles)
    begin
      @(negedge clock);
      if (commit.valid !== 1'b0)
        mismatch("commit.valid", 0, commit.valid);
      compare_status(proc_pkg::st_running, status);
    end
    for (int i = 0; i < mem_words; i++)
    begin
      memory.mem[i] = (i < program_q.size()) ? program_q[i] : fill_word(i);
      ref_mem[i]    = memory.mem[i];
    end
    for (int i = 0; i < proc_pkg::reg_count; i++)
      ref_regs[i] = '0;
    ref_pc     = '0;
    ref_status = proc_pkg::st_running;
    reset      = 1'b0;
    first_fetch.cmd  = proc_pkg::bus_load;   // Address 0 right after reset
    first_fetch.addr = '0;
    first_fetch.data = '0;
    compare_req(first_fetch, mem_req);
    if (commit.valid !== 1'b0)
      mismatch("commit.valid", 0, commit.valid);
    compare_status(proc_pkg::st_running, status);
  endtask

  // Wait for the next commit and check it against the model
  task automatic step_commit();
    proc_pkg::mem_req_t prev_req;
    proc_pkg::mem_req_t exp_data_req;
    proc_pkg::mem_req_t exp_fetch;
    proc_pkg::commit_t  exp_commit;
    proc_pkg::status_t  exp_status;
    int                 gap;
    gap = 0;
    do
    begin
      prev_req = mem_req;      // Ends up as the memory-stage cycle
      @(negedge clock);
      gap++;
    end
    while (commit.valid !== 1'b1);
    model_retire(exp_commit, exp_status, exp_data_req);
    compare_req(exp_data_req, prev_req);
    compare_commit(exp_commit, commit);
    compare_status(exp_status, status);
    if (gap != cycles_per_instr)
      fail_run($sformatf("commit came %0d cycles after its fetch instead of %0d",
                         gap, cycles_per_instr));
    if (exp_status == proc_pkg::st_running)
    begin
      exp_fetch.cmd  = proc_pkg::bus_load;   // Next fetch rides on the commit
      exp_fetch.addr = ref_pc;
      exp_fetch.data = '0;
      compare_req(exp_fetch, mem_req);
    end
  endtask

  task automatic run_until_stop();
    int n;
    n = 0;
    while (ref_status == proc_pkg::st_running)
    begin
      if (n == max_instrs)
        fail_run("program did not stop within the instruction limit");
      step_commit();
      n++;
    end
  endtask

  // Core stays quiet once stopped
  task automatic watch_idle(input int cycles, input proc_pkg::status_t exp_status);
    proc_pkg::mem_req_t idle;
    idle.cmd  = proc_pkg::bus_none;
    idle.addr = '0;
    idle.data = '0;
    repeat (cycles)
    begin
      @(negedge clock);
      compare_req(idle, mem_req);
      compare_status(exp_status, status);
      if (commit.valid !== 1'b0)
        mismatch("commit.valid", 0, commit.valid);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic test_reset();
    program_q.delete();
    program_q.push_back(encode(proc_pkg::op_halt, 0, 0, 0, 0));
    start_program();           // Reset checks live here
    run_until_stop();
  endtask

  task automatic test_arith();
    proc_pkg::word_t r;
    logic [3:0]      op;
    program_q.delete();
    program_q.push_back(encode(proc_pkg::op_addi, 0, 0, 0, 16'h1234));  // r0 write dropped
    program_q.push_back(encode(proc_pkg::op_or, 1, 0, 0, 0));           // Reads r0
    for (int i = 1; i < proc_pkg::reg_count; i++)
      program_q.push_back(encode(proc_pkg::op_addi, i, 0, 0, int'(next_random())));
    for (int i = 0; i < 24; i++)
    begin
      r = next_random();
      case (r % 5)
        0:       op = proc_pkg::op_add;
        1:       op = proc_pkg::op_sub;
        2:       op = proc_pkg::op_and;
        3:       op = proc_pkg::op_or;
        default: op = proc_pkg::op_addi;
      endcase
      program_q.push_back(encode(op, int'(r[18:16]), int'(r[21:19]), int'(r[24:22]),
                                 int'(next_random())));
    end
    program_q.push_back(encode(proc_pkg::op_add, 2, 0, 0, 0));          // r0 still zero
    program_q.push_back(encode(proc_pkg::op_halt, 0, 0, 0, 0));
    start_program();
    run_until_stop();
  endtask

  task automatic test_mem();
    program_q.delete();
    program_q.push_back(encode(proc_pkg::op_addi, 1, 0, 0, 100));       // Base
    program_q.push_back(encode(proc_pkg::op_addi, 2, 0, 0, int'(next_random())));
    program_q.push_back(encode(proc_pkg::op_store, 0, 1, 2, 5));
    program_q.push_back(encode(proc_pkg::op_addi, 2, 0, 0, 0));         // Clobber source
    program_q.push_back(encode(proc_pkg::op_load, 3, 1, 0, 5));
    program_q.push_back(encode(proc_pkg::op_addi, 4, 0, 0, int'(next_random())));
    program_q.push_back(encode(proc_pkg::op_store, 0, 1, 4, -3));       // Negative offset
    program_q.push_back(encode(proc_pkg::op_load, 5, 1, 0, -3));
    program_q.push_back(encode(proc_pkg::op_halt, 0, 0, 0, 0));
    start_program();
    run_until_stop();
  endtask

  // Three-pass loop covering forward taken, not taken and backward taken beq
  task automatic test_branch();
    program_q.delete();
    program_q.push_back(encode(proc_pkg::op_addi, 1, 0, 0, 3));
    program_q.push_back(encode(proc_pkg::op_addi, 2, 0, 0, 0));
    program_q.push_back(encode(proc_pkg::op_addi, 2, 2, 0, 1));         // Loop head
    program_q.push_back(encode(proc_pkg::op_beq, 0, 2, 1, 1));          // Exit to halt
    program_q.push_back(encode(proc_pkg::op_beq, 0, 0, 0, -3));         // Back to head
    program_q.push_back(encode(proc_pkg::op_halt, 0, 0, 0, 0));
    start_program();
    run_until_stop();
  endtask

  task automatic test_halt();
    program_q.delete();
    program_q.push_back(encode(proc_pkg::op_addi, 1, 0, 0, 9));
    program_q.push_back(encode(proc_pkg::op_halt, 0, 0, 0, 0));
    program_q.push_back(encode(proc_pkg::op_addi, 2, 0, 0, 1));         // Never fetched
    start_program();
    run_until_stop();
    watch_idle(20, proc_pkg::st_halted);
  endtask

  task automatic test_illegal();
    program_q.delete();
    program_q.push_back(encode(proc_pkg::op_addi, 1, 0, 0, 5));
    program_q.push_back(encode(4'h9, 1, 1, 1, 7));                      // No write to r1
    start_program();
    run_until_stop();
    watch_idle(8, proc_pkg::st_illegal);
  endtask

  initial
  begin
    reset       = 1'b1;
    rng_state   = 32'd14964;
    cycle_count = 0;
    test_reset();
    test_arith();
    test_mem();
    test_branch();
    test_halt();
    test_illegal();
    $display("test passed");
    $finish;
  end

endmodule

/* logic/decode_unit.sv */
// Field decode and register file with one cycle of latency
// Register 0 reads as zero and ignores writes
// A commit write lands at the clock edge ending the commit cycle
// The next instruction decodes after that edge and needs no bypass
// All registers read zero after reset

`timescale 1ns/10ps

module decode_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  proc_pkg::fetch_pkt_t  fetched,
  input  proc_pkg::commit_t     commit,
  output proc_pkg::decode_pkt_t decoded
);

  proc_pkg::word_t    rf [proc_pkg::reg_count];
  proc_pkg::opcode_t  opcode;
  proc_pkg::reg_idx_t rd;
  proc_pkg::reg_idx_t ra;
  proc_pkg::reg_idx_t rb;
  logic [proc_pkg::imm_bits-1:0] imm_raw;
  proc_pkg::word_t    a_value;
  proc_pkg::word_t    b_value;
  proc_pkg::word_t    imm_ext;

  ////////////////////////////////////////////////////////////////////
  // Field split
  ////////////////////////////////////////////////////////////////////
  assign opcode  = proc_pkg::opcode_t'(fetched.inst[proc_pkg::op_hi:proc_pkg::op_lo]);
  assign rd      = fetched.inst[proc_pkg::rd_hi:proc_pkg::rd_lo];
  assign ra      = fetched.inst[proc_pkg::ra_hi:proc_pkg::ra_lo];
  assign rb      = fetched.inst[proc_pkg::rb_hi:proc_pkg::rb_lo];
  assign imm_raw = fetched.inst[proc_pkg::imm_hi:proc_pkg::imm_lo];

  assign imm_ext = {{(proc_pkg::xlen - proc_pkg::imm_bits){imm_raw[proc_pkg::imm_bits-1]}},
                    imm_raw};

  // Operand reads with r0 hardwired to zero
  assign a_value = (ra == '0) ? '0 : rf[ra];
  assign b_value = (rb == '0) ? '0 : rf[rb];

  ////////////////////////////////////////////////////////////////////
  // Register file write port
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < proc_pkg::reg_count; i++)
        rf[i] <= '0;
    end
    else if (commit.valid && commit.wr_en && (commit.wr_idx != '0))
    begin
      rf[commit.wr_idx] <= commit.wr_data;
    end
  end

  // Decode packet register
  always_ff @(posedge clock)
  begin
    decoded.valid  <= fetched.valid;
    decoded.pc     <= fetched.pc;
    decoded.opcode <= opcode;
    decoded.rd     <= rd;
    decoded.a      <= a_value;
    decoded.b      <= b_value;
    decoded.imm    <= imm_ext;
    if (reset)
      decoded.valid <= 1'b0;   // Bubble out of reset
  end

endmodule

/* logic/execute_unit.sv */
// ALU, branch compare and branch target, one cycle
// Loads and stores form their word address here as a plus immediate
// Branch target is relative to the next pc: pc + 1 + imm
// Illegal opcodes pass through with a zero result and no redirect

`timescale 1ns/10ps

module execute_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  proc_pkg::decode_pkt_t decoded,
  output proc_pkg::exec_pkt_t   executed
);

  proc_pkg::word_t result;
  logic            take_branch;
  proc_pkg::word_t target;

  always_comb
  begin
    case (decoded.opcode)
      proc_pkg::op_add:   result = decoded.a + decoded.b;
      proc_pkg::op_sub:   result = decoded.a - decoded.b;
      proc_pkg::op_and:   result = decoded.a & decoded.b;
      proc_pkg::op_or:    result = decoded.a | decoded.b;
      proc_pkg::op_addi,
      proc_pkg::op_load,
      proc_pkg::op_store: result = decoded.a + decoded.imm;  // Value or address
      default:            result = '0;   // beq, halt, illegal
    endcase
  end

  // beq only
  assign take_branch = (decoded.opcode == proc_pkg::op_beq) && (decoded.a == decoded.b);
  assign target      = decoded.pc + proc_pkg::word_t'(1) + decoded.imm;

  ////////////////////////////////////////////////////////////////////
  // Execute packet register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    executed.valid      <= decoded.valid;
    executed.pc         <= decoded.pc;
    executed.opcode     <= decoded.opcode;
    executed.rd         <= decoded.rd;
    executed.result     <= result;
    executed.store_data <= decoded.b;
    executed.redirect   <= take_branch;
    executed.target     <= target;
    if (reset)
      executed.valid <= 1'b0;
  end

endmodule

/* logic/fetch_unit.sv */
// Program counter and fetch issue
// Fetch goes out in the first cycle after reset, then once per commit
// Request is combinational, instruction word captured at the end of that cycle
// A taken branch at commit steers the same-cycle fetch to the target

`timescale 1ns/10ps

module fetch_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  proc_pkg::commit_t    commit,
  input  proc_pkg::status_t    status,
  output logic                 fetch_req,
  output proc_pkg::word_t      fetch_addr,
  input  proc_pkg::word_t      mem_rdata,
  output proc_pkg::fetch_pkt_t fetched
);

  proc_pkg::word_t pc;          // Next sequential fetch address
  logic            issue_pending; // First fetch after reset

  // Next fetch rides on the commit of the previous instruction
  assign fetch_req  = issue_pending | (commit.valid & (status == proc_pkg::st_running));
  assign fetch_addr = (commit.valid && commit.redirect) ? commit.target : pc;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc            <= '0;
      issue_pending <= 1'b1;   // Held until reset drops
    end
    else
    begin
      issue_pending <= 1'b0;
      if (fetch_req)
        pc <= fetch_addr + proc_pkg::word_t'(1);
    end
  end

  // Fetch packet register
  always_ff @(posedge clock)
  begin
    fetched.valid <= fetch_req;
    fetched.pc    <= fetch_addr;
    fetched.inst  <= mem_rdata;   // Memory answers in the same cycle
    if (reset)
      fetched.valid <= 1'b0;
  end

endmodule

/* logic/memory_unit.sv */
// Memory stage, purely combinational
// Owns the single memory port; a data access wins over a fetch
// With one instruction in flight the two never collide
// Memory read data is expected in the same cycle as the request

`timescale 1ns/10ps

module memory_unit (
  input  proc_pkg::exec_pkt_t executed,
  input  logic                fetch_req,
  input  proc_pkg::word_t     fetch_addr,
  input  proc_pkg::word_t     mem_rdata,
  output proc_pkg::mem_req_t  mem_req,
  output proc_pkg::exec_pkt_t mem_result
);

  logic is_load;
  logic is_store;

  assign is_load  = executed.valid && (executed.opcode == proc_pkg::op_load);
  assign is_store = executed.valid && (executed.opcode == proc_pkg::op_store);

  // Port arbitration
  always_comb
  begin
    mem_req.cmd  = proc_pkg::bus_none;
    mem_req.addr = fetch_addr;
    mem_req.data = executed.store_data;
    if (is_load)
    begin
      mem_req.cmd  = proc_pkg::bus_load;
      mem_req.addr = executed.result;
    end
    else if (is_store)
    begin
      mem_req.cmd  = proc_pkg::bus_store;
      mem_req.addr = executed.result;
    end
    else if (fetch_req)
      mem_req.cmd = proc_pkg::bus_load;   // Instruction fetch
  end

  // Load data replaces the address, all else passes
  always_comb
  begin
    mem_result = executed;
    if (is_load)
      mem_result.result = mem_rdata;
  end

endmodule

/* logic/pipeline_top.sv */
// Five-stage in-order core on one shared memory port
// Memory must answer reads combinationally in the request cycle
// One instruction in flight: commit every 4 cycles, next fetch on commit
// Halted or illegal status stops fetch until reset

`timescale 1ns/10ps

module pipeline_top (
  input  logic                clock,
  input  logic                reset,
  input  proc_pkg::word_t     mem_rdata,
  output proc_pkg::mem_req_t  mem_req,
  output proc_pkg::commit_t   commit,
  output proc_pkg::status_t   status
);

  logic                  fetch_req;
  proc_pkg::word_t       fetch_addr;
  proc_pkg::fetch_pkt_t  fetched;
  proc_pkg::decode_pkt_t decoded;
  proc_pkg::exec_pkt_t   executed;
  proc_pkg::exec_pkt_t   mem_result;

  ////////////////////////////////////////////////////////////////////
  // Stages in program order
  ////////////////////////////////////////////////////////////////////
  fetch_unit fetch (
    .clock      (clock),
    .reset      (reset),
    .commit     (commit),       // Issue and redirect
    .status     (status),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .mem_rdata  (mem_rdata),
    .fetched    (fetched)
  );

  decode_unit decode (
    .clock   (clock),
    .reset   (reset),
    .fetched (fetched),
    .commit  (commit),          // Register write back
    .decoded (decoded)
  );

  execute_unit execute (
    .clock    (clock),
    .reset    (reset),
    .decoded  (decoded),
    .executed (executed)
  );

  memory_unit memory (
    .executed   (executed),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .mem_rdata  (mem_rdata),
    .mem_req    (mem_req),
    .mem_result (mem_result)
  );

  retire_unit retire (
    .clock      (clock),
    .reset      (reset),
    .mem_result (mem_result),
    .commit     (commit),
    .status     (status)
  );

endmodule

/* logic/proc_pkg.sv */
// Shared widths, opcodes and stage packets for the five-stage core
// Word addressed throughout: pc, instruction and data addresses count words
// One instruction in flight, so packets carry no hazard or stall fields
// Opcodes outside opcode_t's named values are illegal and stop the core

package proc_pkg;

  localparam int xlen         = 32;  // Data and address width
  localparam int reg_count    = 8;   // Architectural registers
  localparam int reg_idx_bits = 3;

  ////////////////////////////////////////////////////////////////////
  // Instruction layout
  ////////////////////////////////////////////////////////////////////
  localparam int op_hi  = 31;
  localparam int op_lo  = 28;
  localparam int rd_hi  = 27;
  localparam int rd_lo  = 25;
  localparam int ra_hi  = 24;
  localparam int ra_lo  = 22;
  localparam int rb_hi  = 21;
  localparam int rb_lo  = 19;
  localparam int imm_hi = 15;        // Bits 18..16 unused
  localparam int imm_lo = 0;
  localparam int imm_bits = imm_hi - imm_lo + 1;

  typedef logic [xlen-1:0]         word_t;
  typedef logic [reg_idx_bits-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    op_add   = 4'h0,
    op_sub   = 4'h1,
    op_and   = 4'h2,
    op_or    = 4'h3,
    op_addi  = 4'h4,
    op_load  = 4'h5,
    op_store = 4'h6,
    op_beq   = 4'h7,
    op_halt  = 4'h8   // 4'h9..4'hf illegal
  } opcode_t;

  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_cmd_t;

  typedef struct packed {
    bus_cmd_t cmd;
    word_t    addr;
    word_t    data;   // Only meaningful with bus_store
  } mem_req_t;

  typedef enum logic [1:0] {
    st_running = 2'd0,
    st_halted  = 2'd1,
    st_illegal = 2'd2
  } status_t;

  ////////////////////////////////////////////////////////////////////
  // Stage packets, valid low marks a bubble
  ////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    opcode_t  opcode;
    reg_idx_t rd;
    word_t    a;        // Register ra
    word_t    b;        // Register rb
    word_t    imm;      // Sign extended
  } decode_pkt_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    opcode_t  opcode;
    reg_idx_t rd;
    word_t    result;     // ALU value or load/store address
    word_t    store_data;
    logic     redirect;   // Taken beq
    word_t    target;
  } exec_pkt_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    logic     redirect;
    word_t    target;
  } commit_t;

endpackage

/* logic/retire_unit.sv */
// Retire register, commit packet and run status
// Commit is valid for one cycle, the cycle after the retire register loads
// Status leaves st_running on a retiring halt or illegal opcode and stays
// there until reset; no register write for either

`timescale 1ns/10ps

module retire_unit (
  input  logic                clock,
  input  logic                reset,
  input  proc_pkg::exec_pkt_t mem_result,
  output proc_pkg::commit_t   commit,
  output proc_pkg::status_t   status
);

  proc_pkg::exec_pkt_t retire_q;
  logic                writes_reg;

  always_ff @(posedge clock)
  begin
    retire_q <= mem_result;
    if (reset)
      retire_q.valid <= 1'b0;
  end

  ////////////////////////////////////////////////////////////////////
  // Run status, updated alongside the retire register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      status <= proc_pkg::st_running;
    else if (mem_result.valid && (status == proc_pkg::st_running))
    begin
      case (mem_result.opcode)
        proc_pkg::op_halt: status <= proc_pkg::st_halted;
        proc_pkg::op_add, proc_pkg::op_sub, proc_pkg::op_and, proc_pkg::op_or,
        proc_pkg::op_addi, proc_pkg::op_load, proc_pkg::op_store,
        proc_pkg::op_beq:  status <= proc_pkg::st_running;
        default:           status <= proc_pkg::st_illegal;
      endcase
    end
  end

  // Which ops produce a register value
  always_comb
  begin
    case (retire_q.opcode)
      proc_pkg::op_add, proc_pkg::op_sub, proc_pkg::op_and, proc_pkg::op_or,
      proc_pkg::op_addi, proc_pkg::op_load: writes_reg = 1'b1;
      default:                              writes_reg = 1'b0;
    endcase
  end

  // Commit packet
  assign commit.valid    = retire_q.valid;
  assign commit.pc       = retire_q.pc;
  assign commit.wr_en    = retire_q.valid & writes_reg & (retire_q.rd != '0);  // r0 drop
  assign commit.wr_idx   = retire_q.rd;
  assign commit.wr_data  = retire_q.result;
  assign commit.redirect = retire_q.valid & retire_q.redirect;
  assign commit.target   = retire_q.target;

endmodule

/* sim.f */
logic/proc_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/retire_unit.sv
logic/pipeline_top.sv
bench/mem_model.sv
bench/pipeline_tb.sv
